// File: files.f
+incdir+include
verilog/cpc_mem_pkg.sv
verilog/boot_loader.sv
verilog/multiface_two.sv
verilog/mem_request_mux.sv
verilog/cpc_mem_top.sv
tb/tb_cpc_mem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log
set -e
set -o pipefail

cd "$(dirname "$0")"

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing \
	-f files.f \
	--top-module tb_cpc_mem \
	-Mdir "$build_dir" \
	-o tb_cpc_mem

"./$build_dir/tb_cpc_mem" | tee "$log_file"

if grep -qx "sim passed" "$log_file"; then
	echo "result: pass"
else
	echo "result: FAIL"
	exit 1
fi

// File: include/tb_cpc_mem_tasks.svh
// Testbench drive, wait and compare tasks
`ifndef tb_cpc_mem_tasks_svh
`define tb_cpc_mem_tasks_svh

////////////////////////////////////////////////////////////
// Timing

// Step to the drive point just after the rising edge
task automatic next_cycle();
	@(posedge clk_sys);
	#2;
endtask

// Step to the sample point in mid cycle
task automatic settle();
	#5;
endtask

////////////////////////////////////////////////////////////
// Test bookkeeping

task automatic start_test(input string name);
	test_name = name;
	test_errs = err_count;
endtask

task automatic end_test();
	test_count++;
	if (err_count == test_errs)
		$display("%s: ok", test_name);
	else
		$display("%s: %0d errors", test_name, err_count - test_errs);
endtask

////////////////////////////////////////////////////////////
// Waits

function automatic logic watched_level(input int sel);
	case (sel)
		watch_machine_reset: return machine_reset;
		watch_nmi:           return nmi;
		default:             return mf2_en;
	endcase
endfunction

// Called at the drive point and returns at the sample point
task automatic wait_level(input string what, input int sel, input logic level);
	int n;
	n = 0;
	settle();
	while (watched_level(sel) !== level && n < wait_limit) begin
		next_cycle();
		settle();
		n++;
	end
	if (watched_level(sel) !== level) begin
		$display("%s: timeout while waiting for %s to become %b", test_name, what, level);
		err_count++;
	end
endtask

// Wait for the CPU read data to reach a value
task automatic wait_cpu_din(input logic [7:0] value);
	int n;
	n = 0;
	settle();
	while (cpu_din !== value && n < wait_limit) begin
		next_cycle();
		settle();
		n++;
	end
endtask

// NMI button followed by the 0x0066 fetch
task automatic enter_multiface();
	next_cycle();
	key_nmi = 1'b1;
	wait_level("nmi", watch_nmi, 1'b1);
	next_cycle();
	key_nmi  = 1'b0;
	cpu_addr = 16'h0066;
	m1       = 1'b1;
	wait_level("mf2_en", watch_mf2_en, 1'b1);
	next_cycle();
	m1 = 1'b0;
endtask

// I/O write to FEEA
task automatic leave_multiface();
	next_cycle();
	cpu_addr = 16'hfeea;
	io_wr    = 1'b1;
	wait_level("mf2_en", watch_mf2_en, 1'b0);
	next_cycle();
	io_wr = 1'b0;
endtask

////////////////////////////////////////////////////////////
// Compares

task automatic check_addr(input string what, input cpc_mem_pkg::mem_addr_u exp,
	input cpc_mem_pkg::mem_addr_u act);
	if (act.flat !== exp.flat) begin
		$display("ERR %s %s expected %h actual %h", test_name, what, exp.flat, act.flat);
		err_count++;
	end
endtask

task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
	if (act !== exp) begin
		$display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
		err_count++;
	end
endtask

task automatic check_bank(input string what, input logic [bank_w-1:0] exp,
	input logic [bank_w-1:0] act);
	if (act !== exp) begin
		$display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
		err_count++;
	end
endtask

task automatic check_bit(input string what, input logic exp, input logic act);
	if (act !== exp) begin
		$display("ERR %s %s expected %b actual %b", test_name, what, exp, act);
		err_count++;
	end
endtask

`endif

// File: tb/tb_cpc_mem.sv
// CPC memory request testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cpc_mem;

	localparam int bank_w              = 2;
	localparam int wait_limit          = 40; // Cycles per wait
	localparam int watch_machine_reset = 0;
	localparam int watch_nmi           = 1;
	localparam int watch_mf2_en        = 2;

	logic                   clk_sys;
	logic                   reset;
	logic                   ioctl_download;
	logic [7:0]             ioctl_index;
	logic                   ioctl_wr;
	logic [24:0]            ioctl_addr;
	logic [7:0]             ioctl_dout;
	logic [15:0]            ioctl_file_ext;
	logic [15:0]            cpu_addr;
	logic [7:0]             cpu_dout;
	cpc_mem_pkg::mem_addr_u mem_addr;
	logic                   mem_rd;
	logic                   mem_wr;
	logic                   io_wr;
	logic                   m1;
	logic                   key_nmi;
	logic [7:0]             ram_dout;
	logic                   model_sel;
	logic [1:0]             mf2_mode;

	logic                                sdram_oe;
	logic                                sdram_we;
	logic [cpc_mem_pkg::mem_addr_w-1:0]  sdram_addr;
	logic [bank_w-1:0]                   sdram_bank;
	logic [7:0]                          sdram_din;
	logic [7:0]                          cpu_din;
	logic                                nmi;
	logic                                mf2_en;
	logic                                machine_reset;
	logic                                model;

	string test_name;
	int    test_errs;
	int    err_count;
	int    test_count;
	int    seed;

	cpc_mem_top #(.bank_w(bank_w), .mf2_ram_words(8192)) cpc_mem_top_inst (
		.clk_sys (clk_sys), .reset (reset),
		.ioctl_download (ioctl_download), .ioctl_index (ioctl_index),
		.ioctl_wr (ioctl_wr), .ioctl_addr (ioctl_addr), .ioctl_dout (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext),
		.cpu_addr (cpu_addr), .cpu_dout (cpu_dout), .mem_addr (mem_addr),
		.mem_rd (mem_rd), .mem_wr (mem_wr), .io_wr (io_wr), .m1 (m1),
		.key_nmi (key_nmi), .ram_dout (ram_dout), .model_sel (model_sel),
		.mf2_mode (mf2_mode),
		.sdram_oe (sdram_oe), .sdram_we (sdram_we), .sdram_addr (sdram_addr),
		.sdram_bank (sdram_bank), .sdram_din (sdram_din), .cpu_din (cpu_din),
		.nmi (nmi), .mf2_en (mf2_en), .machine_reset (machine_reset), .model (model)
	);

	`include "tb_cpc_mem_tasks.svh"

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// Expected address from a 9 bit page and an offset
	function automatic cpc_mem_pkg::mem_addr_u page_addr(input logic [8:0] page,
		input logic [13:0] ofs);
		cpc_mem_pkg::mem_addr_u a;
		a.f.rom  = page[8];
		a.f.page = page[7:0];
		a.f.ofs  = ofs;
		return a;
	endfunction

	function automatic logic [8:0] seg_page(input int seg);
		case (seg % 4)
			0:       return cpc_mem_pkg::lower_rom_page;
			1:       return cpc_mem_pkg::amsdos_page;
			2:       return cpc_mem_pkg::upper_rom_page;
			default: return cpc_mem_pkg::mf2_page; // Segment 3 of each bank
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Tests

	task automatic test_reset_state();
		start_test("reset_state");
		wait_level("machine_reset", watch_machine_reset, 1'b0);
		check_bit("nmi", 1'b0, nmi);
		check_bit("mf2_en", 1'b0, mf2_en);
		check_bit("sdram_we", 1'b0, sdram_we);
		check_bit("sdram_oe", 1'b0, sdram_oe);
		end_test();
	endtask

	task automatic test_rom_download();
		logic [13:0] ofs;
		start_test("rom_download");
		next_cycle();
		ioctl_index    = 8'd0;
		ioctl_download = 1'b1;
		ioctl_wr       = 1'b1; // Held for the whole image
		mem_rd         = 1'b1; // CPU read held off by the loader
		wait_level("machine_reset", watch_machine_reset, 1'b1);
		for (int seg = 0; seg < 8; seg++) begin
			ofs = 14'(seg * 1111 + 5);
			next_cycle();
			ioctl_addr = 25'(seg * 16384 + int'(ofs));
			settle();
			check_bit("sdram_we", 1'b1, sdram_we);
			check_bit("sdram_oe", 1'b0, sdram_oe);
			check_addr("sdram_addr", page_addr(seg_page(seg), ofs), sdram_addr);
			check_bank("sdram_bank", bank_w'(seg / 4), sdram_bank);
		end
		next_cycle();
		ioctl_addr = 25'(8 * 16384);
		settle();
		check_bit("segment 8 sdram_we", 1'b0, sdram_we);
		next_cycle();
		ioctl_wr       = 1'b0;
		ioctl_download = 1'b0;
		ioctl_addr     = '0;
		mem_rd         = 1'b0;
		end_test();
	endtask

	// One byte at a time so the ROM map gets its falling strobe edges
	task automatic test_expansion_download();
		start_test("expansion_download");
		wait_level("machine_reset", watch_machine_reset, 1'b0);
		next_cycle();
		model_sel      = 1'b1;
		ioctl_index    = 8'd3;
		ioctl_file_ext = "1A";
		ioctl_addr     = 25'h0005;
		ioctl_download = 1'b1;
		wait_level("machine_reset", watch_machine_reset, 1'b1);
		next_cycle();
		settle();
		check_bit("model", 1'b1, model);
		for (int seg = 0; seg < 2; seg++) begin
			next_cycle();
			ioctl_addr = 25'(seg * 16384 + 5);
			ioctl_dout = 8'(seg + 8'h40);
			ioctl_wr   = 1'b1;
			settle();
			check_bit("sdram_we", 1'b1, sdram_we);
			check_addr("sdram_addr", page_addr({1'b1, 8'h1a + 8'(seg)}, 14'h0005), sdram_addr);
			check_bank("sdram_bank", 2'd1, sdram_bank);
			check_byte("sdram_din", 8'(seg + 8'h40), sdram_din);
			next_cycle();
			ioctl_wr = 1'b0;
		end
		next_cycle();
		ioctl_download = 1'b0;

		// ZZ goes to page 0 outside the ROM area
		wait_level("machine_reset", watch_machine_reset, 1'b0);
		next_cycle();
		ioctl_file_ext = "ZZ";
		ioctl_addr     = 25'h8010;
		ioctl_download = 1'b1;
		wait_level("machine_reset", watch_machine_reset, 1'b1);
		next_cycle();
		ioctl_wr = 1'b1;
		settle();
		check_addr("ZZ sdram_addr", page_addr(9'h002, 14'h0010), sdram_addr);
		check_bank("ZZ sdram_bank", 2'd1, sdram_bank);
		next_cycle();
		ioctl_wr       = 1'b0;
		ioctl_download = 1'b0;
		end_test();
	endtask

	task automatic test_rom_mask();
		start_test("rom_mask");
		wait_level("machine_reset", watch_machine_reset, 1'b0);
		next_cycle();
		mem_addr = page_addr({1'b1, 8'h1a}, 14'h0123);
		mem_rd   = 1'b1;
		settle();
		check_bit("loaded page sdram_oe", 1'b1, sdram_oe);
		check_addr("sdram_addr", page_addr({1'b1, 8'h1a}, 14'h0123), sdram_addr);
		next_cycle();
		mem_addr = page_addr({1'b1, 8'h40}, 14'h0123);
		settle();
		check_bit("unloaded page sdram_oe", 1'b0, sdram_oe);
		next_cycle();
		mem_rd = 1'b0;
		end_test();
	endtask

	task automatic test_mf2_entry();
		start_test("mf2_entry");
		enter_multiface();
		settle();
		check_bit("nmi after entry", 1'b0, nmi);
		next_cycle();
		cpu_addr = 16'h0100;
		mem_addr = page_addr(cpc_mem_pkg::lower_rom_page, 14'h0100);
		mem_rd   = 1'b1;
		settle();
		check_addr("paged sdram_addr", page_addr(cpc_mem_pkg::mf2_page, 14'h0100), sdram_addr);
		next_cycle();
		mem_rd = 1'b0;
		leave_multiface();
		end_test();
	endtask

	task automatic test_register_shadow();
		logic [7:0] data;
		start_test("register_shadow");
		data = 8'($random(seed));
		next_cycle();
		cpu_addr = 16'h7f00; // Mode write to the gate array
		cpu_dout = 8'h8d;
		io_wr    = 1'b1;
		next_cycle();
		io_wr = 1'b0;
		enter_multiface();
		next_cycle();
		cpu_addr      = 16'h3fef;
		mem_addr.flat = 23'h003fef;
		mem_rd        = 1'b1;
		ram_dout      = 8'hff;
		wait_cpu_din(8'h8d);
		check_byte("shadowed mode byte", 8'h8d, cpu_din);

		next_cycle();
		mem_rd        = 1'b0;
		cpu_addr      = 16'h2010;
		mem_addr.flat = 23'h002010;
		cpu_dout      = data;
		mem_wr        = 1'b1;
		settle();
		check_bit("sdram_we in MF2 RAM", 1'b0, sdram_we);
		next_cycle();
		mem_wr = 1'b0;
		next_cycle();
		next_cycle();
		mem_rd = 1'b1; // Byte now comes back from the RAM array
		wait_cpu_din(data);
		check_byte("RAM read-back", data, cpu_din);
		next_cycle();
		mem_rd = 1'b0;
		leave_multiface();
		end_test();
	endtask

	task automatic test_mf2_disabled();
		int n;
		start_test("mf2_disabled");
		next_cycle();
		mf2_mode = 2'd2;
		next_cycle();
		key_nmi = 1'b1;
		settle();
		for (n = 0; n < 8 && nmi !== 1'b1; n++) begin
			next_cycle();
			settle();
		end
		check_bit("nmi", 1'b0, nmi);
		next_cycle();
		key_nmi  = 1'b0;
		mf2_mode = 2'd0;
		end_test();
	endtask

	////////////////////////////////////////////////////////////
	// Sequence

	initial begin
		reset          = 1'b1;
		ioctl_download = 1'b0;
		ioctl_index    = '0;
		ioctl_wr       = 1'b0;
		ioctl_addr     = '0;
		ioctl_dout     = '0;
		ioctl_file_ext = '0;
		cpu_addr       = '0;
		cpu_dout       = '0;
		mem_addr       = '0;
		mem_rd         = 1'b0;
		mem_wr         = 1'b0;
		io_wr          = 1'b0;
		m1             = 1'b0;
		key_nmi        = 1'b0;
		ram_dout       = 8'hff; // Idle SDRAM reads as all-ones
		model_sel      = 1'b0;
		mf2_mode       = 2'd0;
		seed           = 18;
		err_count      = 0;
		test_count     = 0;
		test_errs      = 0;
		test_name      = "";

		repeat (10) @(posedge clk_sys);
		#2;
		reset = 1'b0;

		test_reset_state();
		test_rom_download();
		test_expansion_download();
		test_rom_mask();
		test_mf2_entry();
		test_register_shadow();
		test_mf2_disabled();

		$display("tests %0d, errors %0d", test_count, err_count);
		if (err_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog/cpc_mem_top.sv
// CPC memory request top level
`timescale 1ns/1ps
`default_nettype none

module cpc_mem_top #(
	parameter int bank_w        = 2,
	parameter int mf2_ram_words = 8192
) (
	input  wire                                clk_sys,
	input  wire                                reset,
	// Loader
	input  wire                                ioctl_download,
	input  wire  [7:0]                         ioctl_index,
	input  wire                                ioctl_wr,
	input  wire  [24:0]                        ioctl_addr,
	input  wire  [7:0]                         ioctl_dout,
	input  wire  [15:0]                        ioctl_file_ext,
	// CPU side
	input  wire  [15:0]                        cpu_addr,
	input  wire  [7:0]                         cpu_dout,
	input  wire  [cpc_mem_pkg::mem_addr_w-1:0] mem_addr,
	input  wire                                mem_rd,
	input  wire                                mem_wr,
	input  wire                                io_wr,
	input  wire                                m1,
	input  wire                                key_nmi,
	input  wire  [7:0]                         ram_dout,
	input  wire                                model_sel,
	input  wire  [1:0]                         mf2_mode,
	// SDRAM request
	output logic                               sdram_oe,
	output logic                               sdram_we,
	output logic [cpc_mem_pkg::mem_addr_w-1:0] sdram_addr,
	output logic [bank_w-1:0]                  sdram_bank,
	output logic [7:0]                         sdram_din,
	output logic [7:0]                         cpu_din,
	output logic                               nmi,
	output logic                               mf2_en,
	output logic                               machine_reset,
	output logic                               model
);

	logic                   boot_we;
	cpc_mem_pkg::mem_addr_u boot_addr;
	logic [bank_w-1:0]      boot_bank;
	logic [7:0]             boot_din;
	logic [255:0]           rom_map;
	logic                   boot_loading;
	logic                   mf2_rom_en;
	logic                   mf2_ram_en;
	logic [7:0]             mf2_dout;

	// Machine held in reset while a ROM image loads
	always_ff @(posedge clk_sys) begin
		machine_reset <= reset | boot_loading;
		if (machine_reset)
			model <= model_sel; // 664 vs 6128 memory
	end

	boot_loader #(.bank_w(bank_w)) boot_loader_inst (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout),
		.ioctl_file_ext (ioctl_file_ext),
		.model          (model),
		.boot_we        (boot_we),
		.boot_addr      (boot_addr),
		.boot_bank      (boot_bank),
		.boot_din       (boot_din),
		.rom_map        (rom_map),
		.loading        (boot_loading)
	);

	multiface_two #(.ram_words(mf2_ram_words)) multiface_two_inst (
		.clk_sys    (clk_sys),
		.reset      (machine_reset),
		.mf2_mode   (mf2_mode),
		.cpu_addr   (cpu_addr),
		.cpu_dout   (cpu_dout),
		.mem_addr   (mem_addr),
		.mem_rd     (mem_rd),
		.mem_wr     (mem_wr),
		.io_wr      (io_wr),
		.m1         (m1),
		.key_nmi    (key_nmi),
		.nmi        (nmi),
		.mf2_en     (mf2_en),
		.mf2_rom_en (mf2_rom_en),
		.mf2_ram_en (mf2_ram_en),
		.mf2_dout   (mf2_dout)
	);

	mem_request_mux #(.bank_w(bank_w)) mem_request_mux_inst (
		.machine_reset (machine_reset),
		.model         (model),
		.boot_we       (boot_we),
		.boot_addr     (boot_addr),
		.boot_bank     (boot_bank),
		.boot_din      (boot_din),
		.rom_map       (rom_map),
		.cpu_addr      (cpu_addr),
		.cpu_dout      (cpu_dout),
		.mem_addr      (mem_addr),
		.mem_rd        (mem_rd),
		.mem_wr        (mem_wr),
		.mf2_rom_en    (mf2_rom_en),
		.mf2_ram_en    (mf2_ram_en),
		.mf2_mode      (mf2_mode),
		.ram_dout      (ram_dout),
		.mf2_dout      (mf2_dout),
		.sdram_oe      (sdram_oe),
		.sdram_we      (sdram_we),
		.sdram_addr    (sdram_addr),
		.sdram_bank    (sdram_bank),
		.sdram_din     (sdram_din),
		.cpu_din       (cpu_din)
	);

endmodule

`default_nettype wire

// File: verilog/mem_request_mux.sv
// SDRAM request combiner
`timescale 1ns/1ps
`default_nettype none

module mem_request_mux #(
	parameter int bank_w = 2
) (
	input  wire                          machine_reset,
	input  wire                          model,
	input  wire                          boot_we,
	input  wire  cpc_mem_pkg::mem_addr_u boot_addr,
	input  wire  [bank_w-1:0]            boot_bank,
	input  wire  [7:0]                   boot_din,
	input  wire  [255:0]                 rom_map,
	input  wire  [15:0]                  cpu_addr,
	input  wire  [7:0]                   cpu_dout,
	input  wire  cpc_mem_pkg::mem_addr_u mem_addr,
	input  wire                          mem_rd,
	input  wire                          mem_wr,
	input  wire                          mf2_rom_en,
	input  wire                          mf2_ram_en,
	input  wire  [1:0]                   mf2_mode,
	input  wire  [7:0]                   ram_dout,
	input  wire  [7:0]                   mf2_dout,
	output logic                         sdram_oe,
	output logic                         sdram_we,
	output logic [cpc_mem_pkg::mem_addr_w-1:0] sdram_addr,
	output logic [bank_w-1:0]            sdram_bank,
	output logic [7:0]                   sdram_din,
	output logic [7:0]                   cpu_din
);

	cpc_mem_pkg::mem_addr_u mf2_addr;
	logic                   mf2_page_off;
	logic                   rom_mask;

	// Multiface ROM overlay keeps the CPU offset
	always_comb begin
		mf2_addr.f.ofs = cpu_addr[13:0];
		{mf2_addr.f.rom, mf2_addr.f.page} = cpc_mem_pkg::mf2_page;
	end

	assign mf2_page_off = ({mem_addr.f.rom, mem_addr.f.page} == cpc_mem_pkg::mf2_page)
		& mf2_mode[1];

	// Unloaded ROM pages read as open bus
	assign rom_mask = mem_addr.f.rom & (~rom_map[mem_addr.f.page] | mf2_page_off);

	always_comb begin
		if (machine_reset) begin // Loader owns the SDRAM
			sdram_oe   = 1'b0;
			sdram_we   = boot_we;
			sdram_addr = boot_addr.flat;
			sdram_bank = boot_bank;
			sdram_din  = boot_din;
		end else begin
			sdram_oe   = mem_rd & ~mf2_ram_en & ~rom_mask;
			sdram_we   = mem_wr & ~mf2_ram_en & ~mf2_rom_en;
			sdram_addr = mf2_rom_en ? mf2_addr.flat : mem_addr.flat;
			sdram_bank = bank_w'(model);
			sdram_din  = cpu_dout;
		end
	end

	assign cpu_din = ram_dout & mf2_dout; // Idle sources drive all-ones

endmodule

`default_nettype wire

// File: verilog/multiface_two.sv
// Multiface Two unit
`timescale 1ns/1ps
`default_nettype none

module multiface_two #(
	parameter int ram_words = 8192
) (
	input  wire                        clk_sys,
	input  wire                        reset,
	input  wire  [1:0]                 mf2_mode,
	input  wire  [15:0]                cpu_addr,
	input  wire  [7:0]                 cpu_dout,
	input  wire  cpc_mem_pkg::mem_addr_u mem_addr,
	input  wire                        mem_rd,
	input  wire                        mem_wr,
	input  wire                        io_wr,
	input  wire                        m1,
	input  wire                        key_nmi,
	output logic                       nmi,
	output logic                       mf2_en,
	output logic                       mf2_rom_en,
	output logic                       mf2_ram_en,
	output logic [7:0]                 mf2_dout
);

	localparam int ram_aw = $clog2(ram_words);

	logic [7:0]        ram [0:ram_words-1];
	logic [ram_aw-1:0] ram_a;
	logic [7:0]        ram_in;
	logic [7:0]        ram_out;
	logic              ram_we;

	logic              hidden;
	logic              old_key_nmi;
	logic              old_m1;
	logic              old_io_wr;
	logic              m1_edge;
	logic              io_edge;
	logic              ctrl_hit;   // FEE8 or FEEA
	logic [4:0]        pen_index;
	logic [3:0]        crtc_reg;
	logic [12:0]       store_addr;
	logic              store_hit;
	logic              store_wr;

	assign mf2_rom_en = mf2_en & (cpu_addr[15:13] == 3'b000); // 0000-1FFF
	assign mf2_ram_en = mf2_en & (cpu_addr[15:13] == 3'b001); // 2000-3FFF
	assign mf2_dout   = (mf2_ram_en & mem_rd) ? ram_out : 8'hff;

	assign m1_edge  = ~old_m1 & m1;
	assign io_edge  = ~old_io_wr & io_wr;
	assign ctrl_hit = cpu_addr[15:2] == cpc_mem_pkg::io_mf2_ctrl;
	assign store_wr = io_edge & ~ctrl_hit & store_hit;

	////////////////////////////////////////////////////////////
	// Hardware register shadow addresses

	always_comb begin
		store_hit  = 1'b1;
		store_addr = '0;
		case (cpu_addr[15:8])
			8'h7f: begin // Gate array
				case (cpu_dout[7:6])
					2'b00: store_addr = cpc_mem_pkg::shadow_pen_index;
					2'b01: store_addr = pen_index[4] ? cpc_mem_pkg::shadow_border
						: {cpc_mem_pkg::shadow_pen_base[12:4], pen_index[3:0]};
					2'b10: store_addr = cpc_mem_pkg::shadow_mode;
					default: store_addr = cpc_mem_pkg::shadow_banking;
				endcase
			end
			8'hbc: store_addr = cpc_mem_pkg::shadow_crtc_sel;
			8'hbd: store_addr = {cpc_mem_pkg::shadow_crtc_base[12:4], crtc_reg};
			8'hf7: store_addr = cpc_mem_pkg::shadow_ppi_ctrl;
			8'hdf: store_addr = cpc_mem_pkg::shadow_upper_rom;
			default: store_hit = 1'b0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// NMI entry, hide and enable control

	always_ff @(posedge clk_sys) begin
		old_key_nmi <= key_nmi;
		old_m1      <= m1;
		old_io_wr   <= io_wr;

		if (reset) begin
			nmi       <= 1'b0;
			mf2_en    <= 1'b0;
			hidden    <= |mf2_mode;
			pen_index <= '0;
			crtc_reg  <= '0;
		end else begin
			if (~old_key_nmi & key_nmi & ~mf2_en & ~mf2_mode[1])
				nmi <= 1'b1;
			if (nmi & m1_edge & (cpu_addr == 16'h0066)) begin // NMI vector fetch
				mf2_en <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end
			if (mf2_en & m1_edge & (cpu_addr == 16'h0065))
				hidden <= 1'b1;

			if (io_edge & ctrl_hit)
				mf2_en <= ~cpu_addr[1] & ~hidden;
			else if (store_wr) begin
				if (cpu_addr[15:8] == 8'h7f && cpu_dout[7:6] == 2'b00)
					pen_index <= cpu_dout[4:0];
				if (cpu_addr[15:8] == 8'hbc)
					crtc_reg <= cpu_dout[3:0];
			end
		end
	end

	// Write request, one cycle behind the access
	always_ff @(posedge clk_sys) begin
		if (reset)
			ram_we <= 1'b0;
		else
			ram_we <= store_wr | (mem_wr & mf2_ram_en);
	end

	always_ff @(posedge clk_sys) begin
		ram_in <= cpu_dout;
		if (store_wr)
			ram_a <= ram_aw'(store_addr);
		else
			ram_a <= mem_addr.f.ofs[ram_aw-1:0];
	end

	// 8 KB RAM
	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			ram[ram_a] <= ram_in;
			ram_out    <= ram_in;
		end else begin
			ram_out <= ram[ram_a];
		end
	end

endmodule

`default_nettype wire

// File: verilog/boot_loader.sv
// ROM download mapper
`timescale 1ns/1ps
`default_nettype none

module boot_loader #(
	parameter int bank_w = 2
) (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire                     ioctl_download,
	input  wire  [7:0]              ioctl_index,
	input  wire                     ioctl_wr,
	input  wire  [24:0]             ioctl_addr,
	input  wire  [7:0]              ioctl_dout,
	input  wire  [15:0]             ioctl_file_ext,
	input  wire                     model,
	output logic                    boot_we,
	output cpc_mem_pkg::mem_addr_u  boot_addr,
	output logic [bank_w-1:0]       boot_bank,
	output logic [7:0]              boot_din,
	output logic [255:0]            rom_map,
	output logic                    loading
);

	// Hex character to nibble, top bit flags a valid digit
	function automatic logic [4:0] hex_digit(input logic [7:0] c);
		logic [4:0] d;
		d = 5'd0;
		if (c >= "0" && c <= "9")
			d = {1'b1, c[3:0]};
		else if (c >= "A" && c <= "F")
			d = {1'b1, c[3:0] + 4'd9};
		return d;
	endfunction

	logic       rom_download;
	logic       ext_download;
	logic       old_download;
	logic       old_wr;
	logic [8:0] page;       // Expansion base page, ROM flag on top
	logic       combo;
	logic [4:0] ext_hi;
	logic [4:0] ext_lo;
	logic [8:0] ext_page;
	logic       ext_combo;
	logic       map_ok;     // Segment has a target page

	assign rom_download = ioctl_download && (ioctl_index == 8'd0);
	assign ext_download = ioctl_download && (ioctl_index == 8'd3);
	assign loading      = rom_download | ext_download;

	////////////////////////////////////////////////////////////
	// Page from the two character extension

	always_comb begin
		ext_hi    = hex_digit(ioctl_file_ext[15:8]);
		ext_lo    = hex_digit(ioctl_file_ext[7:0]);
		ext_page  = cpc_mem_pkg::bad_ext_page;
		ext_combo = 1'b0;
		if (ext_hi[4])
			ext_page[7:4] = ext_hi[3:0];
		if (ext_lo[4])
			ext_page[3:0] = ext_lo[3:0];
		if (ioctl_file_ext == "ZZ")
			ext_page = '0;
		if (ioctl_file_ext == "Z0") begin
			ext_page  = '0;
			ext_combo = 1'b1; // Second part goes to the MF2 page
		end
	end

	////////////////////////////////////////////////////////////
	// Download address mapping

	always_comb begin
		boot_din       = ioctl_dout;
		boot_addr.f.ofs = ioctl_addr[13:0];
		{boot_addr.f.rom, boot_addr.f.page} = cpc_mem_pkg::mf2_page;
		boot_bank      = '0;
		map_ok         = 1'b1;

		if (ext_download) begin
			boot_addr.f.rom  = page[8];
			boot_addr.f.page = page[7:0] + ioctl_addr[21:14];
			boot_bank        = bank_w'(model);
		end else begin
			boot_bank = bank_w'(ioctl_addr[16]); // Segments 4-7 in bank 1
			case (ioctl_addr[24:14])
				11'd0, 11'd4: {boot_addr.f.rom, boot_addr.f.page} = cpc_mem_pkg::lower_rom_page;
				11'd1, 11'd5: {boot_addr.f.rom, boot_addr.f.page} = cpc_mem_pkg::amsdos_page;
				11'd2, 11'd6: {boot_addr.f.rom, boot_addr.f.page} = cpc_mem_pkg::upper_rom_page;
				11'd3, 11'd7: {boot_addr.f.rom, boot_addr.f.page} = cpc_mem_pkg::mf2_page;
				default:      map_ok = 1'b0;
			endcase
		end

		boot_we = loading & ioctl_wr & map_ok;
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_download <= 1'b0;
			old_wr       <= 1'b0;
			page         <= cpc_mem_pkg::bad_ext_page;
			combo        <= 1'b0;
			rom_map      <= '0;
		end else begin
			old_download <= ioctl_download;
			old_wr       <= ioctl_wr;

			if (~old_download & ext_download) begin
				page  <= ext_page;
				combo <= ext_combo;
			end else if (loading & map_ok & old_wr & ~ioctl_wr) begin
				// Byte done, mark its page as present
				if (boot_addr.f.rom)
					rom_map[boot_addr.f.page] <= 1'b1;
				if (combo & (&boot_addr.f.ofs)) begin
					combo <= 1'b0;
					page  <= cpc_mem_pkg::mf2_page;
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/cpc_mem_pkg.sv
// CPC memory request definitions
`default_nettype none

package cpc_mem_pkg;

	////////////////////////////////////////////////////////////
	// Address widths

	localparam int mem_addr_w = 23; // SDRAM byte address
	localparam int page_w     = 8;
	localparam int ofs_w      = 14; // 16 KB page

	// One SDRAM address word, seen flat or split up
	typedef union packed {
		logic [mem_addr_w-1:0] flat;
		struct packed {
			logic              rom;  // ROM area flag
			logic [page_w-1:0] page;
			logic [ofs_w-1:0]  ofs;
		} f;
	} mem_addr_u;

	////////////////////////////////////////////////////////////
	// ROM pages, ROM flag included

	localparam logic [page_w:0] mf2_page       = 9'h1ff; // Multiface ROM
	localparam logic [page_w:0] lower_rom_page = 9'h000;
	localparam logic [page_w:0] amsdos_page    = 9'h100;
	localparam logic [page_w:0] upper_rom_page = 9'h107;
	localparam logic [page_w:0] bad_ext_page   = 9'h1ee; // Unused, for bad extensions

	// FEE8 enables, FEEA disables
	localparam logic [13:0] io_mf2_ctrl = 14'h3fba;

	////////////////////////////////////////////////////////////
	// Shadow locations in the Multiface RAM

	localparam logic [12:0] shadow_pen_index = 13'h1fcf;
	localparam logic [12:0] shadow_border    = 13'h1fdf;
	localparam logic [12:0] shadow_mode      = 13'h1fef;
	localparam logic [12:0] shadow_banking   = 13'h1fff;
	localparam logic [12:0] shadow_crtc_sel  = 13'h1cff;
	localparam logic [12:0] shadow_crtc_base = 13'h1db0; // Plus register number
	localparam logic [12:0] shadow_ppi_ctrl  = 13'h17ff;
	localparam logic [12:0] shadow_upper_rom = 13'h1aac;
	localparam logic [12:0] shadow_pen_base  = 13'h1f90; // Plus pen number

endpackage

`default_nettype wire
